/* all.f */
+incdir+hw
hw/ucodeSeqPkg.sv
hw/controlStore.sv
hw/dispatchMux.sv
hw/returnStack.sv
hw/crAddress.sv
hw/ucodeSeqTop.sv
verification/ucodeSeq_assertions.sv
verification/ucodeSeqTb.sv

/* run.sh */
#!/bin/sh
# Build and run the sequencer testbench, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wall -f all.f --top-module ucodeSeqTb -o simv \
  > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "Something failed" >> sim.log
cat build.log sim.log
if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0

/* verification/ucodeSeqTb.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module ucodeSeqTb
  import ucodeSeqPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic CLK = 1'b0;
  logic rstN, run, force1777;
  csWrite_t csWr;
  dispIn_t dispIn;
  diagWrite_t diagWr;
  logic [2:0] diagSel;
  uAdr_t cradr;
  logic [`CTL_W-1:0] uctl;
  logic [5:0] diagData;

  int errCount = 0;
  int checkCount = 0;
  logic [31:0] rngState = 32'hca99_5cc7;
  // Reference return stack that wraps like the hardware
  uAdr_t modelStack [`STACK_DEPTH];
  logic [`STACK_PTR_W-1:0] modelPtr = '0;
  uAdr_t expAdr;
  uAdr_t diagAdrExp = '0;

  ucodeSeqTop u_dut (
    .CLK(CLK), .rstN(rstN), .run(run), .force1777(force1777), .csWr(csWr),
    .dispIn(dispIn), .diagWr(diagWr), .diagSel(diagSel),
    .cradr(cradr), .uctl(uctl), .diagData(diagData)
  );

  always #5 CLK = ~CLK;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic uWord_t makeWord(uAdr_t j, dispKind_t disp, logic [2:0] cond, logic call);
    uWord_t w;
    logic [31:0] r;
    r = nextRand();
    w.j = j;
    w.disp = disp;
    w.cond = cond;
    w.call = call;
    w.ctl = r[`CTL_W-1:0];
    return w;
  endfunction

  // Odd number of ones in a 6-bit field, counted bit by bit
  function automatic logic hasOddOnes(logic [5:0] bits);
    int ones;
    ones = 0;
    for (int b = 0; b < 6; b++) begin
      if (bits[b]) begin
        ones++;
      end
    end
    return (ones % 2) == 1;
  endfunction

  task automatic checkAdr(string name, uAdr_t got, uAdr_t exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkCtl(string name, logic [`CTL_W-1:0] got, logic [`CTL_W-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkDiag(string name, logic [5:0] got, logic [5:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // Advance to 1 ns after the next rising edge
  task automatic nextCycle();
    @(posedge CLK);
    #1;
  endtask

  // Load one word with the sequencer stopped
  task automatic loadWord(uAdr_t addr, uWord_t w);
    csWr = '{en: 1'b1, addr: addr, word: w};
    nextCycle();
    csWr = '0;
  endtask

  // One executed cycle with an optional trap strobe
  task automatic execute(logic trap);
    run = 1'b1;
    force1777 = trap;
    nextCycle();
    run = 1'b0;
    force1777 = 1'b0;
  endtask

  // Load a word at the current address, execute it, check the landing address
  task automatic stepWord(uWord_t w, uAdr_t next, logic trap);
    loadWord(expAdr, w);
    if (w.call || trap) begin
      modelStack[modelPtr] = expAdr;
      modelPtr++;
    end
    if (w.disp == DISP_RETURN && !trap) begin
      modelPtr--;
    end
    execute(trap);
    expAdr = next;
    checkAdr("cradr", cradr, expAdr);
  endtask

  task automatic reportTest(string name, int errBefore);
    $display("%s finished with %0d errors", name, errCount - errBefore);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic testStraight();
    int e0 = errCount;
    uAdr_t adr [7];
    uWord_t w [7];
    adr[0] = expAdr;
    for (int i = 1; i < 7; i++) begin
      adr[i] = {4'(i), 7'(nextRand())};
    end
    for (int i = 0; i < 7; i++) begin
      w[i] = makeWord((i < 6) ? adr[i+1] : '0, DISP_NONE, 3'd0, 1'b0);
      loadWord(adr[i], w[i]);
    end
    for (int i = 0; i < 6; i++) begin
      execute(1'b0);
      expAdr = w[i].j;
      checkAdr("cradr", cradr, expAdr);
      checkCtl("uctl", uctl, w[i+1].ctl);
    end
    // Stopped sequencer holds its address
    for (int i = 0; i < 3; i++) begin
      nextCycle();
      checkAdr("cradr", cradr, expAdr);
    end
    reportTest("straight-line sequencing", e0);
  endtask

  task automatic testDispatch();
    int e0 = errCount;
    uWord_t w;
    uAdr_t val;
    logic [31:0] r;
    dispKind_t kinds [3] = '{DISP_DRAMJ, DISP_MULTI, DISP_SKIP};
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < 4; i++) begin
        r = nextRand();
        dispIn = r[$bits(dispIn_t)-1:0];
        w = makeWord({7'(nextRand()), 4'b0}, kinds[k], 3'(nextRand()), 1'b0);
        case (kinds[k])
          DISP_DRAMJ: val = dispIn.dramJ;
          DISP_MULTI: val = uAdr_t'(dispIn.multi);
          default: val = uAdr_t'(dispIn.cond[w.cond]);
        endcase
        stepWord(w, w.j | val, 1'b0);
      end
    end
    reportTest("dispatch OR", e0);
  endtask

  task automatic nestAndReturn(int depth);
    uWord_t w;
    uAdr_t ret;
    for (int i = 0; i < depth; i++) begin
      w = makeWord(11'(nextRand()), DISP_NONE, 3'd0, 1'b1);
      stepWord(w, w.j, 1'b0);
    end
    for (int i = 0; i < depth; i++) begin
      w = makeWord({5'(nextRand()), 6'b0}, DISP_RETURN, 3'd0, 1'b0);
      ret = modelStack[modelPtr - 1'b1];
      stepWord(w, w.j | ret, 1'b0);
    end
  endtask

  task automatic testCallReturn();
    int e0 = errCount;
    nestAndReturn(3);
    // Overflow wraps onto the oldest entry
    nestAndReturn(17);
    reportTest("call and return", e0);
  endtask

  task automatic testTrap();
    int e0 = errCount;
    uAdr_t trapped = expAdr;
    stepWord(makeWord(11'(nextRand()), DISP_NONE, 3'd0, 1'b0), '1, 1'b1);
    stepWord(makeWord('0, DISP_RETURN, 3'd0, 1'b0), trapped, 1'b0);
    reportTest("trap", e0);
  endtask

  task automatic testDiag();
    int e0 = errCount;
    uWord_t w;
    uAdr_t topExp;
    diagAdrExp = 11'(nextRand());
    diagWr = '{en: 1'b1, adr: diagAdrExp};
    nextCycle();
    diagWr = '0;
    // Diag dispatch with a call so the stack and pointer read back nonzero
    w = makeWord({5'(nextRand()), 6'b0}, DISP_DIAG, 3'd0, 1'b1);
    stepWord(w, w.j | diagAdrExp, 1'b0);
    // Status word loaded at the landing address without executing
    w = makeWord('0, dispKind_t'(3'(nextRand() % 6)), 3'(nextRand()), 1'(nextRand()));
    loadWord(expAdr, w);
    topExp = modelStack[modelPtr - 1'b1];
    for (int s = 0; s < 6; s++) begin
      logic [5:0] exp;
      diagSel = 3'(s);
      nextCycle();
      case (s)
        0: exp = expAdr[5:0];
        1: exp = {hasOddOnes({w.disp, w.cond}), expAdr[10:6]};
        2: exp = topExp[5:0];
        3: exp = {1'b0, topExp[10:6]};
        4: exp = {1'b0, w.call, modelPtr};
        default: exp = diagAdrExp[5:0];
      endcase
      checkDiag("diagData", diagData, exp);
    end
    reportTest("diagnostics", e0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rstN = 1'b0;
    run = 1'b0;
    force1777 = 1'b0;
    csWr = '0;
    dispIn = '0;
    diagWr = '0;
    diagSel = '0;
    expAdr = '0;
    for (int i = 0; i < 3; i++) begin
      @(posedge CLK);
    end
    #1;
    rstN = 1'b1;
    testStraight();
    testDispatch();
    testCallReturn();
    testTrap();
    testDiag();
    $display("%0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin
    for (int i = 0; i < 20000; i++) begin
      @(posedge CLK);
    end
    $display("Timeout: tests did not finish within 20000 cycles");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/ucodeSeq_assertions.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module ucodeSeqAssertions
  import ucodeSeqPkg::*;
(
  input wire logic     CLK,
  input wire logic     rstN,
  input wire logic     run,
  input wire csWrite_t csWr,
  input wire uAdr_t    cradr,
  input wire uWord_t   curWord
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////
  // Address register
  ////////////////////

  // First cycle out of reset starts at zero
  aResetAdr: assert property (@(posedge CLK) $rose(rstN) |-> cradr == '0)
    else $error("cradr not zero after reset release");

  // Stopped sequencer keeps its address
  aHoldAdr: assert property (@(posedge CLK) disable iff (!rstN) !run |=> $stable(cradr))
    else $error("cradr moved while run low");

  ////////////////////
  // Microcode rules
  ////////////////////

  // Store loads only while stopped
  aLoadStopped: assert property (@(posedge CLK) disable iff (!rstN) !(csWr.en && run))
    else $error("control store written while run high");

  // Call and return in one word is illegal
  aCallReturn: assert property (@(posedge CLK) disable iff (!rstN)
    run && curWord.call |-> curWord.disp != DISP_RETURN)
    else $error("executed word has call with return dispatch");

endmodule

bind ucodeSeqTop ucodeSeqAssertions uAssertions (
  .CLK     (CLK),
  .rstN    (rstN),
  .run     (run),
  .csWr    (csWr),
  .cradr   (cradr),
  .curWord (curWord)
);

`default_nettype wire

/* hw/ucodeSeqTop.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module ucodeSeqTop
  import ucodeSeqPkg::*;
(
  input  wire logic        CLK,
  input  wire logic        rstN,
  input  wire logic        run,
  input  wire logic        force1777,
  input  wire csWrite_t    csWr,
  input  wire dispIn_t     dispIn,
  input  wire diagWrite_t  diagWr,
  input  wire logic [2:0]  diagSel,
  output uAdr_t            cradr,
  output logic [`CTL_W-1:0] uctl,
  output logic [5:0]       diagData
);

  // Word at the current address
  uWord_t curWord;

  ////////////////////
  // Control store
  ////////////////////

  controlStore uControlStore (
    .CLK    (CLK),
    .csWr   (csWr),
    .rdAdr  (cradr),
    .rdWord (curWord)
  );

  // Control field out, same cycle as cradr
  assign uctl = curWord.ctl;

  ////////////////////
  // Address logic
  ////////////////////

  crAddress uCrAddress (
    .CLK       (CLK),
    .rstN      (rstN),
    .run       (run),
    .force1777 (force1777),
    .curWord   (curWord),
    .dispIn    (dispIn),
    .diagWr    (diagWr),
    .diagSel   (diagSel),
    .cradr     (cradr),
    .diagData  (diagData)
  );

endmodule

`default_nettype wire

/* hw/crAddress.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module crAddress
  import ucodeSeqPkg::*;
(
  input  wire logic       CLK,
  input  wire logic       rstN,
  input  wire logic       run,
  input  wire logic       force1777,
  input  wire uWord_t     curWord,
  input  wire dispIn_t    dispIn,
  input  wire diagWrite_t diagWr,
  input  wire logic [2:0] diagSel,
  output uAdr_t           cradr,
  output logic [5:0]      diagData
);

  uAdr_t                   dispVal;
  uAdr_t                   nextAdr;
  uAdr_t                   diagAdr;
  uAdr_t                   top;
  logic [`STACK_PTR_W-1:0] ptr;
  logic                    parity;
  logic                    push;
  logic                    pop;

  ////////////////////
  // Dispatch
  ////////////////////

  dispatchMux uDispatchMux (
    .disp    (curWord.disp),
    .cond    (curWord.cond),
    .dispIn  (dispIn),
    .diagAdr (diagAdr),
    .retAdr  (top),
    .dispVal (dispVal),
    .parity  (parity)
  );

  // Jump field ORed with the dispatch value
  // Trap overrides everything with all ones
  assign nextAdr = force1777 ? '1 : (curWord.j | dispVal);

  // Current address register
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      cradr <= '0;
    end else if (run) begin
      cradr <= nextAdr;
    end
  end

  ////////////////////
  // Call and return
  ////////////////////

  // Call or trap saves the current address
  assign push = run & (curWord.call | force1777);
  // Trap suppresses the return pop
  assign pop  = run & (curWord.disp == DISP_RETURN) & ~force1777;

  returnStack uReturnStack (
    .CLK     (CLK),
    .rstN    (rstN),
    .push    (push),
    .pop     (pop),
    .pushAdr (cradr),
    .top     (top),
    .ptr     (ptr)
  );

  ////////////////////
  // Diagnostics
  ////////////////////

  // Diagnostic dispatch address
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      diagAdr <= '0;
    end else if (diagWr.en) begin
      diagAdr <= diagWr.adr;
    end
  end

  // Status readback, 6 bits per select
  always_comb begin
    case (diagSel)
      3'd0: diagData = cradr[5:0];
      3'd1: diagData = {parity, cradr[10:6]};
      3'd2: diagData = top[5:0];
      3'd3: diagData = {1'b0, top[10:6]};
      // Pointer with the current call bit
      3'd4: diagData = {1'b0, curWord.call, ptr};
      3'd5: diagData = diagAdr[5:0];
      default: diagData = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/returnStack.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module returnStack
  import ucodeSeqPkg::*;
(
  input  wire logic              CLK,
  input  wire logic              rstN,
  input  wire logic              push,
  input  wire logic              pop,
  input  wire uAdr_t             pushAdr,
  output uAdr_t                  top,
  output logic [`STACK_PTR_W-1:0] ptr
);

  ////////////////////
  // Stack storage
  ////////////////////

  // Return addresses
  uAdr_t stack [`STACK_DEPTH];

  // Index of the most recent push
  logic [`STACK_PTR_W-1:0] topIdx;

  // Entry below the pointer
  // Wraps from 0 to the last entry
  assign topIdx = ptr - 1'b1;
  assign top    = stack[topIdx];

  // Push writes at the pointer
  // A push with pop still overwrites this slot
  always_ff @(posedge CLK) begin
    if (push) begin
      stack[ptr] <= pushAdr;
    end
  end

  ////////////////////
  // Stack pointer
  ////////////////////

  // Plain wrapping pointer
  // A 17th nested call lands on the oldest entry
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      ptr <= '0;
    end else if (push && !pop) begin
      ptr <= ptr + 1'b1;
    end else if (pop && !push) begin
      ptr <= ptr - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/dispatchMux.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module dispatchMux
  import ucodeSeqPkg::*;
(
  input  wire dispKind_t  disp,
  input  wire logic [2:0] cond,
  input  wire dispIn_t    dispIn,
  input  wire uAdr_t      diagAdr,
  input  wire uAdr_t      retAdr,
  output uAdr_t           dispVal,
  output logic            parity
);

  ////////////////////
  // Dispatch select
  ////////////////////

  // Zero-extended multiway value
  uAdr_t multiVal;
  // Zero-extended skip bit
  uAdr_t skipVal;

  // Multiway lands in the low 4 bits
  assign multiVal = {{(`UADR_W-4){1'b0}}, dispIn.multi};

  // Skip condition picked by the word's cond field
  // Only bit 0 of the next address can move
  assign skipVal = {{(`UADR_W-1){1'b0}}, dispIn.cond[cond]};

  always_comb begin
    unique case (disp)
      // Diagnostic address from the diag port
      DISP_DIAG: begin
        dispVal = diagAdr;
      end
      // Instruction decode jump
      DISP_DRAMJ: begin
        dispVal = dispIn.dramJ;
      end
      // Subroutine return, top of stack
      DISP_RETURN: begin
        dispVal = retAdr;
      end
      // 4-bit multiway
      DISP_MULTI: begin
        dispVal = multiVal;
      end
      // Skip on condition
      DISP_SKIP: begin
        dispVal = skipVal;
      end
      // No dispatch, plain jump
      default: begin
        dispVal = '0;
      end
    endcase
  end

  ////////////////////
  // Diagnostic parity
  ////////////////////

  // Parity over the dispatch and condition fields
  // Read back through the diag port
  assign parity = ^{disp, cond};

endmodule

`default_nettype wire

/* hw/controlStore.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

module controlStore
  import ucodeSeqPkg::*;
(
  input  wire logic     CLK,
  input  wire csWrite_t csWr,
  input  wire uAdr_t    rdAdr,
  output uWord_t        rdWord
);

  ////////////////////
  // Storage array
  ////////////////////

  // One microword per address
  // Contents come from the loader
  uWord_t mem [`CS_DEPTH];

  // Write port
  // Loaded only while the sequencer is stopped
  always_ff @(posedge CLK) begin
    if (csWr.en) begin
      mem[csWr.addr] <= csWr.word;
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Asynchronous read of the current address
  // The word follows cradr within the same cycle
  assign rdWord = mem[rdAdr];

endmodule

`default_nettype wire

/* hw/ucodeSeqPkg.sv */
`default_nettype none
`include "ucodeSeq_macros.svh"

package ucodeSeqPkg;

  // A microaddress
  typedef logic [`UADR_W-1:0] uAdr_t;

  // Dispatch kind carried in each microword
  // Selects which value gets ORed into the jump field
  typedef enum logic [2:0] {
    DISP_NONE   = 3'd0,
    DISP_DIAG   = 3'd1,
    DISP_DRAMJ  = 3'd2,
    DISP_RETURN = 3'd3,
    DISP_MULTI  = 3'd4,
    DISP_SKIP   = 3'd5
  } dispKind_t;

  // One control store word, 34 bits
  typedef struct packed {
    uAdr_t             j;
    dispKind_t         disp;
    logic [2:0]        cond;
    logic              call;
    logic [`CTL_W-1:0] ctl;
  } uWord_t;

  // Dispatch sources from the rest of the CPU
  // dramJ from instruction decode, multi from the data path
  typedef struct packed {
    uAdr_t              dramJ;
    logic [3:0]         multi;
    logic [`COND_N-1:0] cond;
  } dispIn_t;

  // Control store write port
  typedef struct packed {
    logic   en;
    uAdr_t  addr;
    uWord_t word;
  } csWrite_t;

  // Diagnostic address load
  typedef struct packed {
    logic  en;
    uAdr_t adr;
  } diagWrite_t;

endpackage

`default_nettype wire

/* hw/ucodeSeq_macros.svh */
`ifndef UCODESEQ_MACROS_SVH
`define UCODESEQ_MACROS_SVH

// Microaddress width
// 11 bits covers the 2K control store
`define UADR_W 11

// Control store words
`define CS_DEPTH 2048

// Call/return stack entries
`define STACK_DEPTH 16

// Stack pointer width
// Must satisfy 2**STACK_PTR_W == STACK_DEPTH so the pointer wraps cleanly
`define STACK_PTR_W 4

// Control field width driven out of the sequencer
`define CTL_W 16

// Number of skip conditions selectable by a word
`define COND_N 8

`endif
